// ==== source/l1_defines.svh ====
`ifndef L1_DEFINES_SVH
`define L1_DEFINES_SVH

// Address split is tag | set | word | byte
`define L1_ADDR_W     32
`define L1_TAG_W      23
`define L1_SET_W      4
`define L1_NUM_SETS   16

// One line is one L2 burst
`define L1_WORD_W     3
`define L1_LINE_WORDS 8

`endif

// ==== source/l1_pkg.sv ====
package l1_pkg;

    // Data cache controller
    typedef enum logic [2:0] {
        dc_idle,
        dc_wb_wait,
        dc_wb_busy,
        dc_wb_stream,
        dc_fill_wait,
        dc_fill_busy,
        dc_fill_stream
    } dcache_state_t;

    typedef enum logic [1:0] {
        ic_idle,
        ic_fill_wait,
        ic_fill_busy,
        ic_fill_stream
    } icache_state_t;

    // Who holds the L2 port
    typedef enum logic [1:0] {
        own_none,
        own_data,
        own_instr
    } l2_owner_t;

endpackage

// ==== source/cache_line_store.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module cache_line_store (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rreq,
    input  logic                  wreq,
    input  logic [`L1_ADDR_W-1:0] addr,
    input  logic [`L1_ADDR_W-1:0] wdata,
    input  logic [3:0]            wmask,
    input  logic [`L1_SET_W-1:0]  set_index,
    input  logic [`L1_ADDR_W-1:0] peek_addr,
    output logic                  hit,
    output logic [`L1_ADDR_W-1:0] rdata,
    output logic                  peek_hit,
    output logic [`L1_ADDR_W-1:0] peek_rdata,
    output logic [`L1_TAG_W-1:0]  tag,
    input  logic                  valid,
    input  logic                  tag_wr,
    input  logic [`L1_TAG_W-1:0]  new_tag
);
    localparam int OFF_W = `L1_WORD_W + 2;

    logic [`L1_ADDR_W-1:0] words [`L1_LINE_WORDS];
    logic                  match;
    logic                  peek_match;
    logic [`L1_WORD_W-1:0] word_sel;
    logic [`L1_WORD_W-1:0] peek_sel;

    assign word_sel = addr[2 +: `L1_WORD_W];
    assign peek_sel = peek_addr[2 +: `L1_WORD_W];

    // Tag match alone lets a refill write before the line turns valid
    assign match = (addr[OFF_W +: `L1_SET_W] == set_index) &&
                   (addr[`L1_ADDR_W-1 -: `L1_TAG_W] == tag);
    assign peek_match = (peek_addr[OFF_W +: `L1_SET_W] == set_index) &&
                        (peek_addr[`L1_ADDR_W-1 -: `L1_TAG_W] == tag);

    assign hit = valid && match && (rreq || wreq);
    assign rdata = hit ? words[word_sel] : '0;   // Zero so the owner can OR all sets
    assign peek_hit = valid && peek_match;
    assign peek_rdata = peek_hit ? words[peek_sel] : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            tag <= '0;
        end else if (tag_wr) begin
            tag <= new_tag;
        end
    end

    always_ff @(posedge clk) begin
        if (wreq && match) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask[b]) begin
                    words[word_sel][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
        end
    end

endmodule

// ==== source/dcache.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module dcache (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            rreq,
    input  logic                            wreq,
    input  logic [`L1_ADDR_W-1:0]           addr,
    input  logic [`L1_ADDR_W-1:0]           wdata,
    input  logic [3:0]                      wmask,
    output logic [`L1_ADDR_W-1:0]           rdata,
    output logic                            miss,
    input  logic [`L1_ADDR_W-1:0]           peek_addr,
    output logic [`L1_ADDR_W-1:0]           peek_rdata,
    output logic                            peek_miss,
    output logic                            l2_rreq,
    output logic                            l2_wreq,
    output logic [`L1_ADDR_W-1:0]           l2_addr,
    output logic [`L1_ADDR_W-1:0]           l2_wdata,
    input  logic [`L1_ADDR_W-1:0]           l2_rdata,
    input  logic                            l2_busy,
    output logic [`L1_TAG_W+`L1_SET_W-1:0]  invalid_line,
    output logic                            invalid_req
);
    import l1_pkg::*;

    localparam int OFF_W = `L1_WORD_W + 2;

    dcache_state_t state;

    logic [`L1_TAG_W-1:0]    tag_addr;
    logic [`L1_SET_W-1:0]    set_addr;
    logic [`L1_ADDR_W-1:0]   line_addr;
    logic [`L1_ADDR_W-1:0]   victim_addr;

    // Store control, either the core or the controller
    logic                    use_external;
    logic                    rreq_int;
    logic                    wreq_int;
    logic [`L1_ADDR_W-1:0]   addr_int;
    logic [`L1_ADDR_W-1:0]   wdata_int;

    logic [`L1_NUM_SETS-1:0] valid_bits;
    logic [`L1_NUM_SETS-1:0] dirty_bits;
    logic [`L1_NUM_SETS-1:0] hit_arr;
    logic [`L1_NUM_SETS-1:0] peek_hit_arr;
    logic [`L1_ADDR_W-1:0]   rdata_arr [`L1_NUM_SETS];
    logic [`L1_ADDR_W-1:0]   peek_arr [`L1_NUM_SETS];
    logic [`L1_TAG_W-1:0]    unit_tag [`L1_NUM_SETS];
    logic                    unit_hit;

    assign tag_addr = addr[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign set_addr = addr[OFF_W +: `L1_SET_W];
    assign line_addr = {tag_addr, set_addr, {OFF_W{1'b0}}};
    assign victim_addr = {unit_tag[set_addr], set_addr, {OFF_W{1'b0}}};

    for (genvar g = 0; g < `L1_NUM_SETS; g++) begin : g_sets
        cache_line_store line_inst (
            .clk        (clk),
            .reset      (reset),
            .rreq       (use_external ? rreq : rreq_int),
            .wreq       (use_external ? wreq : wreq_int),
            .addr       (use_external ? addr : addr_int),
            .wdata      (use_external ? wdata : wdata_int),
            .wmask      (use_external ? wmask : 4'hF),
            .set_index  (`L1_SET_W'(g)),
            .peek_addr  (peek_addr),
            .hit        (hit_arr[g]),
            .rdata      (rdata_arr[g]),
            .peek_hit   (peek_hit_arr[g]),
            .peek_rdata (peek_arr[g]),
            .tag        (unit_tag[g]),
            .valid      (valid_bits[g]),
            .tag_wr     (state == dc_fill_wait && set_addr == `L1_SET_W'(g)),
            .new_tag    (tag_addr)
        );
    end

    always_comb begin
        rdata = '0;
        peek_rdata = '0;
        for (int i = 0; i < `L1_NUM_SETS; i++) begin
            rdata |= rdata_arr[i];
            peek_rdata |= peek_arr[i];
        end
    end

    assign unit_hit = |hit_arr;
    assign peek_miss = ~|peek_hit_arr;
    assign miss = (rreq || wreq) && (!unit_hit || state != dc_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= dc_idle;
            use_external <= 1'b1;
            rreq_int <= 1'b0;
            wreq_int <= 1'b0;
            l2_rreq <= 1'b0;
            l2_wreq <= 1'b0;
            invalid_req <= 1'b0;
            valid_bits <= '0;
            dirty_bits <= '0;
        end else begin
            case (state)
                dc_idle: begin
                    if (wreq && unit_hit) begin
                        dirty_bits[set_addr] <= 1'b1;
                    end
                    if ((rreq || wreq) && !unit_hit) begin
                        use_external <= 1'b0;
                        if (valid_bits[set_addr] && dirty_bits[set_addr]) begin
                            state <= dc_wb_wait;
                            l2_wreq <= 1'b1;
                            l2_addr <= victim_addr;
                            rreq_int <= 1'b1;   // Read the victim out of the store
                            addr_int <= victim_addr;
                            invalid_line <= {unit_tag[set_addr], set_addr};
                        end else begin
                            state <= dc_fill_wait;
                            l2_rreq <= 1'b1;
                            l2_addr <= line_addr;
                        end
                    end
                end
                dc_wb_wait: begin
                    l2_wreq <= 1'b0;
                    state <= dc_wb_busy;
                end
                dc_wb_busy: begin
                    if (!l2_busy) begin
                        l2_wdata <= rdata;
                        addr_int <= addr_int + `L1_ADDR_W'(4);
                        state <= dc_wb_stream;
                    end
                end
                dc_wb_stream: begin
                    l2_wdata <= rdata;
                    addr_int <= addr_int + `L1_ADDR_W'(4);
                    if (addr_int[2 +: `L1_WORD_W] == '0) begin   // Wrapped, all 8 sent
                        state <= dc_fill_wait;
                        rreq_int <= 1'b0;
                        l2_rreq <= 1'b1;
                        l2_addr <= line_addr;
                        invalid_req <= 1'b1;
                    end
                end
                dc_fill_wait: begin
                    l2_rreq <= 1'b0;
                    invalid_req <= 1'b0;
                    valid_bits[set_addr] <= 1'b0;
                    state <= dc_fill_busy;
                end
                dc_fill_busy: begin
                    if (!l2_busy) begin
                        addr_int <= line_addr;
                        wreq_int <= 1'b1;
                        wdata_int <= l2_rdata;
                        state <= dc_fill_stream;
                    end
                end
                dc_fill_stream: begin
                    wdata_int <= l2_rdata;
                    addr_int <= addr_int + `L1_ADDR_W'(4);
                    if (addr_int[2 +: `L1_WORD_W] == '1) begin
                        wreq_int <= 1'b0;
                        use_external <= 1'b1;
                        valid_bits[set_addr] <= 1'b1;
                        dirty_bits[set_addr] <= 1'b0;
                        state <= dc_idle;
                    end
                end
                default: state <= dc_idle;
            endcase
        end
    end

endmodule

// ==== source/icache.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module icache (
    input  logic                           clk,
    input  logic                           reset,
    input  logic                           fetch_req,
    input  logic [`L1_ADDR_W-1:0]          fetch_addr,
    output logic [`L1_ADDR_W-1:0]          fetch_data,
    output logic                           fetch_miss,
    input  logic [`L1_TAG_W+`L1_SET_W-1:0] invalid_line,
    input  logic                           invalid_req,
    output logic                           l2_rreq,
    output logic [`L1_ADDR_W-1:0]          l2_addr,
    input  logic [`L1_ADDR_W-1:0]          l2_rdata,
    input  logic                           l2_busy
);
    import l1_pkg::*;

    localparam int OFF_W = `L1_WORD_W + 2;

    icache_state_t state;

    logic [`L1_TAG_W-1:0]    tag_addr;
    logic [`L1_SET_W-1:0]    set_addr;
    logic [`L1_SET_W-1:0]    inv_set;
    logic [`L1_TAG_W-1:0]    inv_tag;
    logic                    use_external;
    logic                    wreq_int;
    logic [`L1_ADDR_W-1:0]   addr_int;
    logic [`L1_ADDR_W-1:0]   wdata_int;
    logic                    fill_kill;
    logic                    inv_hits_fill;
    logic [`L1_NUM_SETS-1:0] valid_bits;
    logic [`L1_NUM_SETS-1:0] hit_arr;
    logic [`L1_ADDR_W-1:0]   rdata_arr [`L1_NUM_SETS];
    logic [`L1_TAG_W-1:0]    unit_tag [`L1_NUM_SETS];

    assign tag_addr = fetch_addr[`L1_ADDR_W-1 -: `L1_TAG_W];
    assign set_addr = fetch_addr[OFF_W +: `L1_SET_W];
    assign inv_set = invalid_line[`L1_SET_W-1:0];
    assign inv_tag = invalid_line[`L1_SET_W +: `L1_TAG_W];
    assign inv_hits_fill = invalid_req && state != ic_idle && invalid_line == {tag_addr, set_addr};

    for (genvar g = 0; g < `L1_NUM_SETS; g++) begin : g_sets
        cache_line_store line_inst (
            .clk        (clk),
            .reset      (reset),
            .rreq       (use_external && fetch_req),
            .wreq       (wreq_int),
            .addr       (use_external ? fetch_addr : addr_int),
            .wdata      (wdata_int),
            .wmask      (4'hF),
            .set_index  (`L1_SET_W'(g)),
            .peek_addr  ('0),
            .hit        (hit_arr[g]),
            .rdata      (rdata_arr[g]),
            .peek_hit   (),
            .peek_rdata (),
            .tag        (unit_tag[g]),
            .valid      (valid_bits[g]),
            .tag_wr     (state == ic_fill_wait && set_addr == `L1_SET_W'(g)),
            .new_tag    (tag_addr)
        );
    end

    always_comb begin
        fetch_data = '0;
        for (int i = 0; i < `L1_NUM_SETS; i++) begin
            fetch_data |= rdata_arr[i];
        end
    end

    assign fetch_miss = fetch_req && (!(|hit_arr) || state != ic_idle);

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= ic_idle;
            use_external <= 1'b1;
            wreq_int <= 1'b0;
            l2_rreq <= 1'b0;
            fill_kill <= 1'b0;
            valid_bits <= '0;
        end else begin
            if (inv_hits_fill) begin
                fill_kill <= 1'b1;
            end
            case (state)
                ic_idle: begin
                    if (fetch_req && !(|hit_arr)) begin
                        use_external <= 1'b0;
                        valid_bits[set_addr] <= 1'b0;
                        fill_kill <= 1'b0;
                        l2_rreq <= 1'b1;
                        l2_addr <= {tag_addr, set_addr, {OFF_W{1'b0}}};
                        state <= ic_fill_wait;
                    end
                end
                ic_fill_wait: begin
                    l2_rreq <= 1'b0;
                    state <= ic_fill_busy;
                end
                ic_fill_busy: begin
                    if (!l2_busy) begin
                        addr_int <= {tag_addr, set_addr, {OFF_W{1'b0}}};
                        wreq_int <= 1'b1;
                        wdata_int <= l2_rdata;
                        state <= ic_fill_stream;
                    end
                end
                ic_fill_stream: begin
                    wdata_int <= l2_rdata;
                    addr_int <= addr_int + `L1_ADDR_W'(4);
                    if (addr_int[2 +: `L1_WORD_W] == '1) begin
                        wreq_int <= 1'b0;
                        use_external <= 1'b1;
                        // Line written back meanwhile, so refetch
                        valid_bits[set_addr] <= !(fill_kill || inv_hits_fill);
                        state <= ic_idle;
                    end
                end
                default: state <= ic_idle;
            endcase
            if (invalid_req && valid_bits[inv_set] && unit_tag[inv_set] == inv_tag) begin
                valid_bits[inv_set] <= 1'b0;
            end
        end
    end

endmodule

// ==== source/l2_arbiter.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module l2_arbiter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  d_rreq,
    input  logic                  d_wreq,
    input  logic [`L1_ADDR_W-1:0] d_addr,
    input  logic [`L1_ADDR_W-1:0] d_wdata,
    output logic                  d_busy,
    output logic [`L1_ADDR_W-1:0] d_rdata,
    input  logic                  i_rreq,
    input  logic [`L1_ADDR_W-1:0] i_addr,
    output logic                  i_busy,
    output logic [`L1_ADDR_W-1:0] i_rdata,
    output logic                  l2_rreq,
    output logic                  l2_wreq,
    output logic [`L1_ADDR_W-1:0] l2_addr,
    output logic [`L1_ADDR_W-1:0] l2_wdata,
    input  logic [`L1_ADDR_W-1:0] l2_rdata,
    input  logic                  l2_busy
);
    import l1_pkg::*;

    l2_owner_t owner;

    logic                  is_write;
    logic [`L1_WORD_W:0]   count;
    logic                  pend_d;
    logic                  pend_d_wr;
    logic [`L1_ADDR_W-1:0] pend_d_addr;
    logic                  pend_i;
    logic [`L1_ADDR_W-1:0] pend_i_addr;
    logic                  word_cycle;
    logic                  last_word;

    // Busy low after the forwarded pulse; write words trail busy by one cycle
    assign word_cycle = owner != own_none && !l2_rreq && !l2_wreq && !l2_busy;
    assign last_word = word_cycle && count == (`L1_WORD_W+1)'(`L1_LINE_WORDS - 1) + is_write;

    assign d_busy = owner != own_data || l2_busy || l2_rreq || l2_wreq;
    assign i_busy = owner != own_instr || l2_busy || l2_rreq;
    assign d_rdata = (owner == own_data) ? l2_rdata : '0;
    assign i_rdata = (owner == own_instr) ? l2_rdata : '0;
    assign l2_wdata = (owner == own_data) ? d_wdata : '0;

    always_ff @(posedge clk) begin
        if (reset) begin
            owner <= own_none;
            l2_rreq <= 1'b0;
            l2_wreq <= 1'b0;
            pend_d <= 1'b0;
            pend_i <= 1'b0;
            count <= '0;
        end else begin
            l2_rreq <= 1'b0;
            l2_wreq <= 1'b0;
            if (d_rreq || d_wreq) begin
                pend_d <= 1'b1;
                pend_d_wr <= d_wreq;
                pend_d_addr <= d_addr;
            end
            if (i_rreq) begin
                pend_i <= 1'b1;
                pend_i_addr <= i_addr;
            end
            if (word_cycle) begin
                count <= count + 1'b1;
            end
            if (last_word) begin
                owner <= own_none;
                count <= '0;
            end
            if (owner == own_none) begin
                if (d_rreq || d_wreq || pend_d) begin   // Data wins a tie
                    owner <= own_data;
                    pend_d <= 1'b0;
                    is_write <= pend_d ? pend_d_wr : d_wreq;
                    l2_wreq <= pend_d ? pend_d_wr : d_wreq;
                    l2_rreq <= pend_d ? !pend_d_wr : d_rreq;
                    l2_addr <= pend_d ? pend_d_addr : d_addr;
                end else if (i_rreq || pend_i) begin
                    owner <= own_instr;
                    pend_i <= 1'b0;
                    is_write <= 1'b0;
                    l2_rreq <= 1'b1;
                    l2_addr <= pend_i ? pend_i_addr : i_addr;
                end
            end
        end
    end

endmodule

// ==== source/l1_subsystem.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module l1_subsystem (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  rreq,
    input  logic                  wreq,
    input  logic [`L1_ADDR_W-1:0] addr,
    input  logic [`L1_ADDR_W-1:0] wdata,
    input  logic [3:0]            wmask,
    output logic [`L1_ADDR_W-1:0] rdata,
    output logic                  miss,
    input  logic [`L1_ADDR_W-1:0] peek_addr,
    output logic [`L1_ADDR_W-1:0] peek_rdata,
    output logic                  peek_miss,
    input  logic                  fetch_req,
    input  logic [`L1_ADDR_W-1:0] fetch_addr,
    output logic [`L1_ADDR_W-1:0] fetch_data,
    output logic                  fetch_miss,
    output logic                  l2_rreq,
    output logic                  l2_wreq,
    output logic [`L1_ADDR_W-1:0] l2_addr,
    output logic [`L1_ADDR_W-1:0] l2_wdata,
    input  logic [`L1_ADDR_W-1:0] l2_rdata,
    input  logic                  l2_busy
);
    logic                           d_rreq;
    logic                           d_wreq;
    logic [`L1_ADDR_W-1:0]          d_addr;
    logic [`L1_ADDR_W-1:0]          d_wdata;
    logic [`L1_ADDR_W-1:0]          d_rdata;
    logic                           d_busy;
    logic                           i_rreq;
    logic [`L1_ADDR_W-1:0]          i_addr;
    logic [`L1_ADDR_W-1:0]          i_rdata;
    logic                           i_busy;
    logic [`L1_TAG_W+`L1_SET_W-1:0] invalid_line;
    logic                           invalid_req;

    dcache dcache_inst (
        .clk, .reset, .rreq, .wreq, .addr, .wdata, .wmask, .rdata, .miss,
        .peek_addr, .peek_rdata, .peek_miss,
        .l2_rreq(d_rreq), .l2_wreq(d_wreq), .l2_addr(d_addr), .l2_wdata(d_wdata),
        .l2_rdata(d_rdata), .l2_busy(d_busy),
        .invalid_line, .invalid_req
    );

    icache icache_inst (
        .clk, .reset, .fetch_req, .fetch_addr, .fetch_data, .fetch_miss,
        .invalid_line, .invalid_req,
        .l2_rreq(i_rreq), .l2_addr(i_addr), .l2_rdata(i_rdata), .l2_busy(i_busy)
    );

    l2_arbiter l2_arbiter_inst (
        .clk, .reset,
        .d_rreq, .d_wreq, .d_addr, .d_wdata, .d_busy, .d_rdata,
        .i_rreq, .i_addr, .i_busy, .i_rdata,
        .l2_rreq, .l2_wreq, .l2_addr, .l2_wdata, .l2_rdata, .l2_busy
    );

endmodule

// ==== tests/l1_subsystem_assertions.sv ====
`timescale 1ns/1ps

module l1_subsystem_assertions (
    input logic clk,
    input logic reset,
    input logic l2_rreq,
    input logic l2_wreq,
    input logic invalid_req
);

    a_one_request: assert property (@(posedge clk) disable iff (reset) !(l2_rreq && l2_wreq))
        else $error("L2 read and write requested together");

    a_rreq_pulse: assert property (@(posedge clk) disable iff (reset) l2_rreq |=> !l2_rreq)
        else $error("l2_rreq longer than one cycle");

    a_wreq_pulse: assert property (@(posedge clk) disable iff (reset) l2_wreq |=> !l2_wreq)
        else $error("l2_wreq longer than one cycle");

    // Outputs come out of reset quiet
    a_reset_quiet: assert property (@(posedge clk) reset |=> !l2_rreq && !l2_wreq && !invalid_req)
        else $error("Request active right after reset");

    a_invalid_pulse: assert property (@(posedge clk) disable iff (reset)
                                      invalid_req |=> !invalid_req)
        else $error("invalid_req longer than one cycle");

endmodule

bind l1_subsystem l1_subsystem_assertions l1_subsystem_assertions_inst (
    .clk         (clk),
    .reset       (reset),
    .l2_rreq     (l2_rreq),
    .l2_wreq     (l2_wreq),
    .invalid_req (invalid_req)
);

// ==== tests/l1_subsystem_tb.sv ====
`timescale 1ns/1ps
`include "l1_defines.svh"

module l1_subsystem_tb;
    localparam int TIMEOUT = 500;

    logic                  clk;
    logic                  reset;
    logic                  rreq;
    logic                  wreq;
    logic [`L1_ADDR_W-1:0] addr;
    logic [`L1_ADDR_W-1:0] wdata;
    logic [3:0]            wmask;
    logic [`L1_ADDR_W-1:0] rdata;
    logic                  miss;
    logic [`L1_ADDR_W-1:0] peek_addr;
    logic [`L1_ADDR_W-1:0] peek_rdata;
    logic                  peek_miss;
    logic                  fetch_req;
    logic [`L1_ADDR_W-1:0] fetch_addr;
    logic [`L1_ADDR_W-1:0] fetch_data;
    logic                  fetch_miss;
    logic                  l2_rreq;
    logic                  l2_wreq;
    logic [`L1_ADDR_W-1:0] l2_addr;
    logic [`L1_ADDR_W-1:0] l2_wdata;
    logic [`L1_ADDR_W-1:0] l2_rdata;
    logic                  l2_busy;

    logic [31:0] l2_mem [int unsigned];   // Word address keyed
    logic [31:0] shadow [int unsigned];
    int          wb_count;
    logic [31:0] last_wb_addr;
    logic        in_burst;

    l1_subsystem l1_subsystem_inst (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    function automatic logic [31:0] init_word(input logic [31:0] a);
        return {a[15:0], a[31:16]} ^ (a * 32'h9E3779B1);
    endfunction

    function automatic logic [31:0] make_addr(input int tag, input int set, input int word);
        return {23'(tag), 4'(set), 3'(word), 2'b00};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                                input logic [3:0] m);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (m[b]) res[8*b +: 8] = d[8*b +: 8];
        end
        return res;
    endfunction

    // Value the core should see after all completed writes
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        if (shadow.exists(a >> 2)) return shadow[a >> 2];
        return init_word({a[31:2], 2'b00});
    endfunction

    function automatic logic [31:0] l2_word(input logic [31:0] a);
        if (l2_mem.exists(a >> 2)) return l2_mem[a >> 2];
        return init_word({a[31:2], 2'b00});
    endfunction

    task automatic stop_run();
        $display("Regression failed");
        $fatal(1, "Simulation stopped on error");
    endtask

    task automatic fail_msg(input string what);
        $display("Error: %s", what);
        stop_run();
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%08h expected 0x%08h", name, got, exp);
            stop_run();
        end
    endtask

    task automatic data_access(input logic is_read, input logic [31:0] a, input logic [31:0] d,
                               input logic [3:0] m, output int waited);
        int cycles;
        @(posedge clk);
        #1;
        rreq = is_read;
        wreq = !is_read;
        addr = a;
        wdata = d;
        wmask = m;
        cycles = 0;
        @(negedge clk);
        while (miss) begin
            cycles++;
            if (cycles > TIMEOUT) fail_msg("data access never completed");
            @(negedge clk);
        end
        waited = cycles;
        @(posedge clk);
        #1;
        if (!is_read) shadow[a >> 2] = merge_bytes(expected_word(a), d, m);
        rreq = 1'b0;
        wreq = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] a, output int waited);
        int cycles;
        @(posedge clk);
        #1;
        fetch_req = 1'b1;
        fetch_addr = a;
        cycles = 0;
        @(negedge clk);
        while (fetch_miss) begin
            cycles++;
            if (cycles > TIMEOUT) fail_msg("instruction fetch never completed");
            @(negedge clk);
        end
        waited = cycles;
        @(posedge clk);
        #1;
        fetch_req = 1'b0;
    endtask

    // L2 memory model
    initial begin
        logic        is_wr;
        logic [31:0] base;
        int          delay;
        l2_busy = 1'b0;
        l2_rdata = '0;
        in_burst = 1'b0;
        forever begin
            @(negedge clk);
            if (!reset && (l2_rreq || l2_wreq)) begin
                is_wr = l2_wreq;
                base = l2_addr;
                check_value("l2_addr[4:0]", 32'(base[4:0]), '0);   // Line aligned
                delay = $urandom_range(5, 0);
                @(posedge clk);
                #1;
                in_burst = 1'b1;
                l2_busy = (delay != 0);
                repeat (delay) begin
                    @(posedge clk);
                    #1;
                end
                l2_busy = 1'b0;
                if (is_wr) begin
                    for (int k = 0; k < `L1_LINE_WORDS; k++) begin
                        @(posedge clk);
                        @(negedge clk);
                        check_value("l2_wdata", l2_wdata, expected_word(base + 32'(4 * k)));
                        l2_mem[(base >> 2) + k] = l2_wdata;
                    end
                    last_wb_addr = base;
                    wb_count++;
                end else begin
                    for (int k = 0; k < `L1_LINE_WORDS; k++) begin
                        l2_rdata = l2_word(base + 32'(4 * k));
                        @(posedge clk);
                        #1;
                    end
                end
                in_burst = 1'b0;
            end
        end
    end

    // Compare process
    always @(negedge clk) begin
        if (!reset) begin
            if (rreq && !miss) check_value("rdata", rdata, expected_word(addr));
            if (fetch_req && !fetch_miss) begin
                check_value("fetch_data", fetch_data, expected_word(fetch_addr));
            end
            if (!peek_miss) check_value("peek_rdata", peek_rdata, expected_word(peek_addr));
            if (in_burst) check_value("l2_rreq|l2_wreq", {31'b0, l2_rreq | l2_wreq}, '0);
        end
    end

    initial begin
        int          waited;
        int          fetch_waited;
        int          wb_before;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] f;
        logic [31:0] wr_addrs [10];
        void'($urandom(59));
        wb_count = 0;
        last_wb_addr = '0;
        reset = 1'b1;
        rreq = 1'b0;
        wreq = 1'b0;
        addr = '0;
        wdata = '0;
        wmask = '0;
        peek_addr = '0;
        fetch_req = 1'b0;
        fetch_addr = '0;
        repeat (3) @(posedge clk);
        #1 reset = 1'b0;

        // Miss, then hit on the same line
        data_access(1'b1, make_addr(1, 3, 2), '0, '0, waited);
        check_value("miss", {31'b0, waited != 0}, 32'd1);
        data_access(1'b1, make_addr(1, 3, 5), '0, '0, waited);
        check_value("miss", 32'(waited), 32'd0);

        // Random masked writes, then read back
        for (int i = 0; i < 10; i++) begin
            wr_addrs[i] = make_addr($urandom_range(3, 0), $urandom_range(15, 0),
                                    $urandom_range(7, 0));
            data_access(1'b0, wr_addrs[i], $urandom, 4'($urandom_range(15, 1)), waited);
        end
        for (int i = 0; i < 10; i++) data_access(1'b1, wr_addrs[i], '0, '0, waited);

        // Dirty eviction
        a = make_addr(2, 7, 1);
        b = make_addr(3, 7, 0);
        data_access(1'b0, a, 32'hCAFE_F00D, 4'hF, waited);
        wb_before = wb_count;
        data_access(1'b1, b, '0, '0, waited);
        check_value("wb_count", 32'(wb_count), 32'(wb_before + 1));
        check_value("l2_addr", last_wb_addr, {a[31:5], 5'b0});
        data_access(1'b1, a, '0, '0, waited);

        // Peek leaves no trace
        peek_addr = make_addr(14, 9, 0);
        @(negedge clk);
        check_value("peek_miss", {31'b0, peek_miss}, 32'd1);
        data_access(1'b1, make_addr(14, 9, 0), '0, '0, waited);
        check_value("miss", {31'b0, waited != 0}, 32'd1);
        peek_addr = a;
        @(negedge clk);
        check_value("peek_miss", {31'b0, peek_miss}, 32'd0);

        // Written-back code reaches the fetch side
        f = make_addr(5, 11, 4);
        fetch(f, waited);
        data_access(1'b0, f, 32'h1357_9BDF, 4'hF, waited);
        wb_before = wb_count;
        data_access(1'b1, make_addr(6, 11, 0), '0, '0, waited);
        check_value("wb_count", 32'(wb_count), 32'(wb_before + 1));
        check_value("l2_addr", last_wb_addr, {f[31:5], 5'b0});
        fetch(f, waited);
        check_value("fetch_miss", {31'b0, waited != 0}, 32'd1);

        // Data and fetch misses together, fresh tags on both sides
        for (int i = 0; i < 10; i++) begin
            a = make_addr(16 + i, $urandom_range(15, 0), $urandom_range(7, 0));
            f = make_addr(32 + i, $urandom_range(15, 0), $urandom_range(7, 0));
            fork
                data_access(1'b1, a, '0, '0, waited);
                fetch(f, fetch_waited);
            join
            check_value("miss", {31'b0, waited != 0}, 32'd1);
            check_value("fetch_miss", {31'b0, fetch_waited != 0}, 32'd1);
        end

        repeat (4) @(posedge clk);
        $display("Regression passed");
        $finish;
    end

endmodule

// ==== l1_subsystem.f ====
+incdir+source
source/l1_pkg.sv
source/cache_line_store.sv
source/dcache.sv
source/icache.sv
source/l2_arbiter.sv
source/l1_subsystem.sv
tests/l1_subsystem_assertions.sv
tests/l1_subsystem_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module l1_subsystem_tb -f l1_subsystem.f -o sim_l1

./obj_dir/sim_l1 > sim.log 2>&1 || true
cat sim.log

if grep -q "Regression failed" sim.log; then
    exit 1
fi
if ! grep -q "Regression passed" sim.log; then
    exit 1
fi
